// ==== src/mem_pkg.sv ====
/*
 * Memory geometry shared by the RAM router, the RAM model and the testbench.
 * Holds the address map and the helpers that turn byte addresses into words and lanes.
 */

package mem_pkg;

    localparam int XLEN       = 32;
    localparam int BE_W       = 4;
    localparam int LANE_W     = $clog2(BE_W);

    localparam int IRAM_WORDS = 2048;
    localparam int DRAM_WORDS = 10240;
    localparam int IRAM_AW    = 11;
    localparam int DRAM_AW    = 14;

    // Instruction RAM sits below this byte address, data RAM from it upwards
    localparam logic [XLEN-1:0] DRAM_BASE = 32'h0001_0000;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////

    function automatic logic is_dram(input logic [XLEN-1:0] addr);
        return addr >= DRAM_BASE;
    endfunction

    function automatic logic [IRAM_AW-1:0] iram_word(input logic [XLEN-1:0] addr);
        return addr[IRAM_AW+LANE_W-1:LANE_W];
    endfunction

    function automatic logic [DRAM_AW-1:0] dram_word(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] offset;
        offset = addr - DRAM_BASE;
        return offset[DRAM_AW+LANE_W-1:LANE_W];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Byte lanes
    //////////////////////////////////////////////////////////////////////

    function automatic logic [BE_W-1:0] lane_mask(input logic [LANE_W-1:0] lane);
        return {{(BE_W-1){1'b0}}, 1'b1} << lane;
    endfunction

    function automatic logic [7:0] lane_byte(input logic [XLEN-1:0] word,
                                             input logic [LANE_W-1:0] lane);
        return word[lane*8 +: 8];
    endfunction

endpackage

// ==== src/host_pkg.sv ====
/*
 * Host loader channel definitions.
 * Command encoding and field widths of the byte-wide request and response.
 */

package host_pkg;

    localparam int HOST_ADDR_W = 32;
    localparam int HOST_DATA_W = 8;

    // One command bit travels with each request
    localparam logic HOST_CMD_READ  = 1'b0;
    localparam logic HOST_CMD_WRITE = 1'b1;

endpackage

// ==== src/mem_port_if.sv ====
/*
 * One word-wide RAM port with a read channel and a byte-enabled write channel.
 * The router holds the requester side, the RAM holds the ram side.
 */

`timescale 1ns/1ns

interface mem_port_if #(
    parameter int DEPTH = 2048
);

    localparam int AW = $clog2(DEPTH);

    logic [AW-1:0]               rd_addr;
    logic [mem_pkg::XLEN-1:0]    rd_data;

    logic                        wr_en;
    logic [AW-1:0]               wr_addr;
    logic [mem_pkg::XLEN-1:0]    wr_data;
    logic [mem_pkg::BE_W-1:0]    wr_be;

    modport requester (
        output rd_addr,
        input  rd_data,
        output wr_en,
        output wr_addr,
        output wr_data,
        output wr_be
    );

    modport ram (
        input  rd_addr,
        output rd_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  wr_be
    );

endinterface

// ==== src/byte_ram.sv ====
/*
 * Behavioural word RAM with a registered read port and a byte-enabled write port.
 * Stands in for the instruction and data RAM macros, sized by DEPTH.
 */

`timescale 1ns/1ns

module byte_ram #(
    parameter int DEPTH = 2048
) (
    input logic       clk_i,
    input logic       rst_n_i,

    mem_port_if.ram   port_if
);

logic [mem_pkg::XLEN-1:0] mem [DEPTH];

// Write lanes independently
always_ff @(posedge clk_i) begin
    if (port_if.wr_en) begin
        for (int i = 0; i < mem_pkg::BE_W; i++) begin
            if (port_if.wr_be[i]) begin
                mem[port_if.wr_addr][i*8 +: 8] <= port_if.wr_data[i*8 +: 8];
            end
        end
    end
end

// Read is registered, same-word write shows up one cycle later
always_ff @(posedge clk_i) begin
    port_if.rd_data <= mem[port_if.rd_addr];
end

//////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////

a_wr_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    port_if.wr_en |-> (port_if.wr_addr < DEPTH)
);

endmodule

// ==== src/ram.sv ====
/*
 * Address router between the core ports, the host sequencer and both RAMs.
 * A host select takes over the RAM it targets, and the host read byte is
 * picked out of the returned word and registered here.
 */

`timescale 1ns/1ns

module ram (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic [mem_pkg::XLEN-1:0]          fetch_addr_i,
    output logic [mem_pkg::XLEN-1:0]          fetch_data_o,

    input  logic [mem_pkg::XLEN-1:0]          load_addr_i,
    output logic [mem_pkg::XLEN-1:0]          load_data_o,

    input  logic                              store_en_i,
    input  logic [mem_pkg::XLEN-1:0]          store_addr_i,
    input  logic [mem_pkg::XLEN-1:0]          store_data_i,
    input  logic [mem_pkg::BE_W-1:0]          store_be_i,

    input  logic                              host_rd_sel_i,
    input  logic                              host_wr_sel_i,
    input  logic                              host_tgt_dram_i,
    input  logic [host_pkg::HOST_ADDR_W-1:0]  host_addr_i,
    input  logic [host_pkg::HOST_DATA_W-1:0]  host_wdata_i,
    output logic [host_pkg::HOST_DATA_W-1:0]  host_byte_o,

    output logic                              mem_busy_o,

    mem_port_if.requester                     iram_port,
    mem_port_if.requester                     dram_port
);

logic                                 host_any;
logic                                 host_iram;
logic                                 host_dram;

logic [mem_pkg::IRAM_AW-1:0]          host_iram_word;
logic [mem_pkg::DRAM_AW-1:0]          host_dram_word;
logic [mem_pkg::BE_W-1:0]             host_be;
logic [mem_pkg::XLEN-1:0]             host_wword;

logic                                 rd_pend_q;
logic [mem_pkg::LANE_W-1:0]           lane_q;
logic                                 lane_dram_q;
logic [mem_pkg::XLEN-1:0]             rd_word;
logic [host_pkg::HOST_DATA_W-1:0]     host_byte_q;

assign host_any  = host_rd_sel_i | host_wr_sel_i;
assign host_iram = host_any & ~host_tgt_dram_i;
assign host_dram = host_any &  host_tgt_dram_i;

assign mem_busy_o = host_any;

// Host write hits one lane, byte copied onto every lane
assign host_iram_word = mem_pkg::iram_word(host_addr_i);
assign host_dram_word = mem_pkg::dram_word(host_addr_i);
assign host_be        = mem_pkg::lane_mask(host_addr_i[mem_pkg::LANE_W-1:0]);
assign host_wword     = {mem_pkg::BE_W{host_wdata_i}};

//////////////////////////////////////////////////////////////////////
// Instruction RAM
//////////////////////////////////////////////////////////////////////

assign iram_port.rd_addr = host_iram ? host_iram_word : mem_pkg::iram_word(fetch_addr_i);

// Only the host writes the instruction RAM
assign iram_port.wr_en   = host_wr_sel_i & ~host_tgt_dram_i;
assign iram_port.wr_addr = host_iram_word;
assign iram_port.wr_data = host_wword;
assign iram_port.wr_be   = host_be;

assign fetch_data_o = iram_port.rd_data;

//////////////////////////////////////////////////////////////////////
// Data RAM
//////////////////////////////////////////////////////////////////////

always_comb begin
    if (host_dram) begin
        dram_port.rd_addr = host_dram_word;
        dram_port.wr_en   = host_wr_sel_i;
        dram_port.wr_addr = host_dram_word;
        dram_port.wr_data = host_wword;
        dram_port.wr_be   = host_be;
    end else begin
        dram_port.rd_addr = mem_pkg::dram_word(load_addr_i);
        dram_port.wr_en   = store_en_i;
        dram_port.wr_addr = mem_pkg::dram_word(store_addr_i);
        dram_port.wr_data = store_data_i;
        dram_port.wr_be   = store_be_i;
    end
end

assign load_data_o = dram_port.rd_data;

//////////////////////////////////////////////////////////////////////
// Host read byte
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        rd_pend_q <= 1'b0;
    end else begin
        rd_pend_q <= host_rd_sel_i;
    end
end

// Lane and target follow the read word by one cycle
always_ff @(posedge clk_i) begin
    if (host_rd_sel_i) begin
        lane_q      <= host_addr_i[mem_pkg::LANE_W-1:0];
        lane_dram_q <= host_tgt_dram_i;
    end
end

assign rd_word = lane_dram_q ? dram_port.rd_data : iram_port.rd_data;

always_ff @(posedge clk_i) begin
    if (rd_pend_q) begin
        host_byte_q <= mem_pkg::lane_byte(rd_word, lane_q);
    end
end

assign host_byte_o = host_byte_q;

//////////////////////////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////////////////////////

a_sel_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(host_rd_sel_i && host_wr_sel_i)
);

endmodule

// ==== src/host_access.sv ====
/*
 * Host byte-access sequencer for the debug loader.
 * Takes one valid/ready request at a time, drives the router select for one
 * cycle and holds the response until the host accepts it.
 */

`timescale 1ns/1ns

module host_access (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic                              host_req_valid_i,
    output logic                              host_req_ready_o,
    input  logic                              host_req_cmd_i,
    input  logic [host_pkg::HOST_ADDR_W-1:0]  host_req_addr_i,
    input  logic [host_pkg::HOST_DATA_W-1:0]  host_req_wdata_i,

    output logic                              host_rsp_valid_o,
    input  logic                              host_rsp_ready_i,
    output logic [host_pkg::HOST_DATA_W-1:0]  host_rsp_rdata_o,

    output logic                              host_rd_sel_o,
    output logic                              host_wr_sel_o,
    output logic                              host_tgt_dram_o,
    output logic [host_pkg::HOST_ADDR_W-1:0]  host_addr_o,
    output logic [host_pkg::HOST_DATA_W-1:0]  host_wdata_o,
    input  logic [host_pkg::HOST_DATA_W-1:0]  host_byte_i
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_WAIT,
    ST_RESP
} state_t;

state_t                               state_q;

logic                                 cmd_q;
logic                                 tgt_dram_q;
logic [host_pkg::HOST_ADDR_W-1:0]     addr_q;
logic [host_pkg::HOST_DATA_W-1:0]     wdata_q;

logic                                 req_fire;
logic                                 is_read;

assign host_req_ready_o = (state_q == ST_IDLE);
assign req_fire         = host_req_valid_i & host_req_ready_o;
assign is_read          = (cmd_q == host_pkg::HOST_CMD_READ);

//////////////////////////////////////////////////////////////////////
// Sequencer
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        state_q <= ST_IDLE;
    end else begin
        case (state_q)
            ST_IDLE: begin
                if (req_fire) begin
                    state_q <= ST_ACCESS;
                end
            end
            // Writes are done once the select cycle ends
            ST_ACCESS: begin
                state_q <= is_read ? ST_WAIT : ST_RESP;
            end
            ST_WAIT: begin
                state_q <= ST_RESP;
            end
            ST_RESP: begin
                if (host_rsp_ready_i) begin
                    state_q <= ST_IDLE;
                end
            end
            default: begin
                state_q <= ST_IDLE;
            end
        endcase
    end
end

// Request fields held for the whole access
always_ff @(posedge clk_i) begin
    if (req_fire) begin
        cmd_q      <= host_req_cmd_i;
        tgt_dram_q <= mem_pkg::is_dram(host_req_addr_i);
        addr_q     <= host_req_addr_i;
        wdata_q    <= host_req_wdata_i;
    end
end

//////////////////////////////////////////////////////////////////////
// Router and response
//////////////////////////////////////////////////////////////////////

assign host_rd_sel_o   = (state_q == ST_ACCESS) & is_read;
assign host_wr_sel_o   = (state_q == ST_ACCESS) & (cmd_q == host_pkg::HOST_CMD_WRITE);
assign host_tgt_dram_o = tgt_dram_q;
assign host_addr_o     = addr_q;
assign host_wdata_o    = wdata_q;

// Read byte is held in the router until the next host read
assign host_rsp_valid_o = (state_q == ST_RESP);
assign host_rsp_rdata_o = (host_rsp_valid_o && is_read) ? host_byte_i : '0;

a_rsp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (host_rsp_valid_o && !host_rsp_ready_i) |=>
        (host_rsp_valid_o && $stable(host_rsp_rdata_o))
);

endmodule

// ==== src/mem_top.sv ====
/*
 * Memory subsystem top with plain core and host ports.
 * Connects the host sequencer, the router and the two RAMs.
 */

`timescale 1ns/1ns

module mem_top (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  logic [mem_pkg::XLEN-1:0]          fetch_addr_i,
    output logic [mem_pkg::XLEN-1:0]          fetch_data_o,

    input  logic [mem_pkg::XLEN-1:0]          load_addr_i,
    output logic [mem_pkg::XLEN-1:0]          load_data_o,

    input  logic                              store_en_i,
    input  logic [mem_pkg::XLEN-1:0]          store_addr_i,
    input  logic [mem_pkg::XLEN-1:0]          store_data_i,
    input  logic [mem_pkg::BE_W-1:0]          store_be_i,

    input  logic                              host_req_valid_i,
    output logic                              host_req_ready_o,
    input  logic                              host_req_cmd_i,
    input  logic [host_pkg::HOST_ADDR_W-1:0]  host_req_addr_i,
    input  logic [host_pkg::HOST_DATA_W-1:0]  host_req_wdata_i,

    output logic                              host_rsp_valid_o,
    input  logic                              host_rsp_ready_i,
    output logic [host_pkg::HOST_DATA_W-1:0]  host_rsp_rdata_o,

    output logic                              mem_busy_o
);

logic                                 host_rd_sel;
logic                                 host_wr_sel;
logic                                 host_tgt_dram;
logic [host_pkg::HOST_ADDR_W-1:0]     host_addr;
logic [host_pkg::HOST_DATA_W-1:0]     host_wdata;
logic [host_pkg::HOST_DATA_W-1:0]     host_byte;

mem_port_if #(.DEPTH(mem_pkg::IRAM_WORDS)) iram_port ();
mem_port_if #(.DEPTH(mem_pkg::DRAM_WORDS)) dram_port ();

host_access i_host_access (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .host_req_valid_i (host_req_valid_i),
    .host_req_ready_o (host_req_ready_o),
    .host_req_cmd_i   (host_req_cmd_i),
    .host_req_addr_i  (host_req_addr_i),
    .host_req_wdata_i (host_req_wdata_i),
    .host_rsp_valid_o (host_rsp_valid_o),
    .host_rsp_ready_i (host_rsp_ready_i),
    .host_rsp_rdata_o (host_rsp_rdata_o),
    .host_rd_sel_o    (host_rd_sel),
    .host_wr_sel_o    (host_wr_sel),
    .host_tgt_dram_o  (host_tgt_dram),
    .host_addr_o      (host_addr),
    .host_wdata_o     (host_wdata),
    .host_byte_i      (host_byte)
);

ram i_ram (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_data_o    (fetch_data_o),
    .load_addr_i     (load_addr_i),
    .load_data_o     (load_data_o),
    .store_en_i      (store_en_i),
    .store_addr_i    (store_addr_i),
    .store_data_i    (store_data_i),
    .store_be_i      (store_be_i),
    .host_rd_sel_i   (host_rd_sel),
    .host_wr_sel_i   (host_wr_sel),
    .host_tgt_dram_i (host_tgt_dram),
    .host_addr_i     (host_addr),
    .host_wdata_i    (host_wdata),
    .host_byte_o     (host_byte),
    .mem_busy_o      (mem_busy_o),
    .iram_port       (iram_port.requester),
    .dram_port       (dram_port.requester)
);

// 8 KiB instruction RAM
byte_ram #(.DEPTH(mem_pkg::IRAM_WORDS)) i_iram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .port_if (iram_port.ram)
);

// 40 KiB data RAM
byte_ram #(.DEPTH(mem_pkg::DRAM_WORDS)) i_dram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .port_if (dram_port.ram)
);

endmodule

// ==== bench/tb_mem_top.sv ====
/*
 * Directed testbench for the memory subsystem top level.
 * Drives host and core traffic, checks against a byte model of both RAMs
 * and ends with one closing report.
 */

`timescale 1ns/1ns

module tb_mem_top;

localparam int CLK_HALF    = 4;
localparam int IRAM_BYTES  = mem_pkg::IRAM_WORDS * mem_pkg::BE_W;
localparam int DRAM_BYTES  = mem_pkg::DRAM_WORDS * mem_pkg::BE_W;
localparam int N_RAND      = 8;

// Operation count over all tests sets the watchdog limit
localparam int N_OPS       = 2*N_RAND + 3*N_RAND + 5 + 9 + N_RAND + 5;
localparam int CYCLE_LIMIT = 20 * N_OPS + 100;

logic        clk_i;
logic        rst_n_i;
logic [31:0] fetch_addr;
logic [31:0] fetch_data;
logic [31:0] load_addr;
logic [31:0] load_data;
logic        store_en;
logic [31:0] store_addr;
logic [31:0] store_data;
logic [3:0]  store_be;
logic        host_req_valid;
logic        host_req_ready;
logic        host_req_cmd;
logic [31:0] host_req_addr;
logic [7:0]  host_req_wdata;
logic        host_rsp_valid;
logic        host_rsp_ready;
logic [7:0]  host_rsp_rdata;
logic        mem_busy;

logic [31:0] lfsr_q;
logic [7:0]  iram_model [IRAM_BYTES];
logic [7:0]  dram_model [DRAM_BYTES];
int unsigned defined_q [$];
int          mismatch_cnt;
int          fail_cnt;
int          cycle_cnt;

mem_top i_mem_top (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .fetch_addr_i     (fetch_addr),
    .fetch_data_o     (fetch_data),
    .load_addr_i      (load_addr),
    .load_data_o      (load_data),
    .store_en_i       (store_en),
    .store_addr_i     (store_addr),
    .store_data_i     (store_data),
    .store_be_i       (store_be),
    .host_req_valid_i (host_req_valid),
    .host_req_ready_o (host_req_ready),
    .host_req_cmd_i   (host_req_cmd),
    .host_req_addr_i  (host_req_addr),
    .host_req_wdata_i (host_req_wdata),
    .host_rsp_valid_o (host_rsp_valid),
    .host_rsp_ready_i (host_rsp_ready),
    .host_rsp_rdata_o (host_rsp_rdata),
    .mem_busy_o       (mem_busy)
);

always #CLK_HALF clk_i = ~clk_i;

always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
        $display("Timeout after %0d cycles, a handshake never completed", cycle_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end
end

//////////////////////////////////////////////////////////////////////
// Random numbers, reference model and reporting
//////////////////////////////////////////////////////////////////////

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val    = {val[30:0], lfsr_q[0]};
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
endfunction

function automatic logic [31:0] rand_dram_word_addr();
    return mem_pkg::DRAM_BASE + ((rand_bits(14) % mem_pkg::DRAM_WORDS) << 2);
endfunction

function automatic logic [7:0] model_byte(input logic [31:0] addr);
    if (addr >= mem_pkg::DRAM_BASE) begin
        return dram_model[addr - mem_pkg::DRAM_BASE];
    end
    return iram_model[addr];
endfunction

function automatic logic [31:0] model_word(input logic [31:0] addr);
    return {model_byte(addr + 3), model_byte(addr + 2), model_byte(addr + 1), model_byte(addr)};
endfunction

function automatic void model_write(input logic [31:0] addr, input logic [7:0] data);
    if (addr >= mem_pkg::DRAM_BASE) begin
        dram_model[addr - mem_pkg::DRAM_BASE] = data;
    end else begin
        iram_model[addr] = data;
    end
    defined_q.push_back(addr);
endfunction

task automatic report_mismatch(input string test, input logic [31:0] exp,
                               input logic [31:0] act);
    mismatch_cnt++;
    $display("Mismatch in %s at %0t: expected %h, actual %h", test, $time, exp, act);
endtask

task automatic report_failure(input string test, input string what);
    fail_cnt++;
    $display("Error in %s at %0t: %s", test, $time, what);
endtask

//////////////////////////////////////////////////////////////////////
// Bus helpers that start and end on a rising edge
//////////////////////////////////////////////////////////////////////

// Returns on the edge where the request is taken
task automatic host_send(input logic cmd, input logic [31:0] addr, input logic [7:0] wdata);
    host_req_valid <= 1'b1;
    host_req_cmd   <= cmd;
    host_req_addr  <= addr;
    host_req_wdata <= wdata;
    do begin
        @(posedge clk_i);
    end while (!host_req_ready);
    host_req_valid <= 1'b0;
endtask

task automatic host_recv(output logic [7:0] rdata, output int edges);
    edges = 0;
    do begin
        @(posedge clk_i);
        edges++;
    end while (!(host_rsp_valid && host_rsp_ready));
    rdata = host_rsp_rdata;
endtask

task automatic host_write(input string test, input logic [31:0] addr, input logic [7:0] data);
    logic [7:0] rdata;
    int         edges;
    host_send(host_pkg::HOST_CMD_WRITE, addr, data);
    host_recv(rdata, edges);
    model_write(addr, data);
    if (edges != 2) begin
        report_failure(test, $sformatf("write response %0d edges after acceptance, not 2", edges));
    end
    if (rdata !== 8'h00) begin
        report_mismatch(test, 32'h0, {24'h0, rdata});
    end
endtask

task automatic host_read_check(input string test, input logic [31:0] addr);
    logic [7:0] rdata;
    logic [7:0] exp;
    int         edges;
    exp = model_byte(addr);
    host_send(host_pkg::HOST_CMD_READ, addr, 8'h00);
    host_recv(rdata, edges);
    if (edges != 3) begin
        report_failure(test, $sformatf("read response %0d edges after acceptance, not 3", edges));
    end
    if (rdata !== exp) begin
        report_mismatch(test, {24'h0, exp}, {24'h0, rdata});
    end
endtask

task automatic core_store(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] be);
    store_en   <= 1'b1;
    store_addr <= addr;
    store_data <= data;
    store_be   <= be;
    @(posedge clk_i);
    store_en   <= 1'b0;
    for (int i = 0; i < mem_pkg::BE_W; i++) begin
        if (be[i]) begin
            model_write(addr + i, data[i*8 +: 8]);
        end
    end
endtask

// Address is taken at the first edge and data settles before the second
task automatic core_load_check(input string test, input logic [31:0] addr);
    load_addr <= addr;
    @(posedge clk_i);
    @(posedge clk_i);
    if (load_data !== model_word(addr)) begin
        report_mismatch(test, model_word(addr), load_data);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////////////////////////

task automatic host_write_read_iram();
    logic [31:0] addrs [N_RAND];
    for (int i = 0; i < N_RAND; i++) begin
        addrs[i] = rand_bits(13);
        host_write("host_write_read_iram", addrs[i], 8'(rand_bits(8)));
    end
    for (int i = 0; i < N_RAND; i++) begin
        host_read_check("host_write_read_iram", addrs[i]);
    end
endtask

task automatic core_store_load();
    logic [31:0] addr;
    for (int i = 0; i < N_RAND; i++) begin
        addr = rand_dram_word_addr();
        core_store(addr, rand_bits(32), 4'hf);
        core_store(addr, rand_bits(32), 4'(rand_bits(4)));
        core_load_check("core_store_load", addr);
    end
endtask

task automatic host_fill_core_fetch();
    logic [31:0] base;
    logic [7:0]  bytes [4];
    logic [31:0] exp;
    base = rand_bits(11) << 2;
    for (int i = 0; i < 4; i++) begin
        bytes[i] = 8'(rand_bits(8));
        host_write("host_fill_core_fetch", base + i, bytes[i]);
    end
    // Lowest address goes to the low byte
    exp = {bytes[3], bytes[2], bytes[1], bytes[0]};
    fetch_addr <= base;
    @(posedge clk_i);
    @(posedge clk_i);
    if (fetch_data !== exp) begin
        report_mismatch("host_fill_core_fetch", exp, fetch_data);
    end
endtask

task automatic host_dram_byte_lanes();
    logic [31:0] base;
    base = rand_dram_word_addr();
    for (int i = 0; i < 4; i++) begin
        host_write("host_dram_byte_lanes", base + i, 8'(rand_bits(8)));
    end
    for (int i = 0; i < 4; i++) begin
        host_read_check("host_dram_byte_lanes", base + i);
    end
    core_load_check("host_dram_byte_lanes", base);
endtask

task automatic host_backpressure();
    logic [31:0] addrs [N_RAND];
    logic [7:0]  exp;
    logic [7:0]  held_data;
    logic        pending;
    logic        held;
    int          sent;
    int          got;
    for (int i = 0; i < N_RAND; i++) begin
        addrs[i] = defined_q[rand_bits(16) % defined_q.size()];
    end
    exp       = '0;
    held_data = '0;
    pending   = 1'b0;
    held      = 1'b0;
    sent      = 0;
    got       = 0;
    host_req_valid <= 1'b1;
    host_req_cmd   <= host_pkg::HOST_CMD_READ;
    host_req_addr  <= addrs[0];
    while (got < N_RAND) begin
        @(posedge clk_i);
        if (held && !host_rsp_valid) begin
            report_failure("host_backpressure", "response dropped before it was accepted");
        end
        if (host_rsp_valid) begin
            if (!pending) begin
                report_failure("host_backpressure", "response without an outstanding read");
            end
            if (held && host_rsp_rdata !== held_data) begin
                report_failure("host_backpressure", "response data changed while held");
            end
            held      = !host_rsp_ready;
            held_data = host_rsp_rdata;
            if (host_rsp_ready) begin
                if (host_rsp_rdata !== exp) begin
                    report_mismatch("host_backpressure", {24'h0, exp}, {24'h0, host_rsp_rdata});
                end
                got++;
                pending = 1'b0;
            end
        end
        if (pending && host_req_ready) begin
            report_failure("host_backpressure", "request ready while a response was pending");
        end
        if (host_req_valid && host_req_ready) begin
            pending = 1'b1;
            exp     = model_byte(addrs[sent]);
            sent++;
            if (sent < N_RAND) begin
                host_req_addr <= addrs[sent];
            end else begin
                host_req_valid <= 1'b0;
            end
        end
        host_rsp_ready <= 1'(rand_bits(1));
    end
    host_rsp_ready <= 1'b1;
endtask

task automatic store_during_host();
    logic [31:0] st_addr;
    logic [31:0] hst_addr;
    logic [7:0]  wbyte;
    logic [7:0]  rdata;
    int          edges;
    st_addr  = rand_dram_word_addr();
    hst_addr = mem_pkg::DRAM_BASE + ((st_addr - mem_pkg::DRAM_BASE + 32'h40) % DRAM_BYTES);
    wbyte    = 8'(rand_bits(8));
    core_store(st_addr, rand_bits(32), 4'hf);
    host_send(host_pkg::HOST_CMD_WRITE, hst_addr, wbyte);
    // The cycle after acceptance belongs to the host
    store_en   <= 1'b1;
    store_addr <= st_addr;
    store_data <= ~model_word(st_addr);
    store_be   <= 4'hf;
    @(posedge clk_i);
    store_en   <= 1'b0;
    if (!mem_busy) begin
        report_failure("store_during_host", "mem_busy_o low in the host access cycle");
    end
    host_recv(rdata, edges);
    model_write(hst_addr, wbyte);
    if (edges != 1) begin
        report_failure("store_during_host",
                       $sformatf("write response %0d edges after the access cycle, not 1",
                                 edges));
    end
    if (rdata !== 8'h00) begin
        report_mismatch("store_during_host", 32'h0, {24'h0, rdata});
    end
    core_load_check("store_during_host", st_addr);
    host_read_check("store_during_host", hst_addr);
endtask

initial begin
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    fetch_addr     = '0;
    load_addr      = mem_pkg::DRAM_BASE;
    store_en       = 1'b0;
    store_addr     = mem_pkg::DRAM_BASE;
    store_data     = '0;
    store_be       = '0;
    host_req_valid = 1'b0;
    host_req_cmd   = host_pkg::HOST_CMD_READ;
    host_req_addr  = '0;
    host_req_wdata = '0;
    host_rsp_ready = 1'b1;
    lfsr_q         = 32'h288f;
    mismatch_cnt   = 0;
    fail_cnt       = 0;
    cycle_cnt      = 0;

    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    if (host_rsp_valid || mem_busy || !host_req_ready) begin
        report_failure("reset", "host side not idle after reset");
    end

    host_write_read_iram();
    core_store_load();
    host_fill_core_fetch();
    host_dram_byte_lanes();
    host_backpressure();
    store_during_host();

    $display("Closing report: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

// ==== vlog.f ====
src/mem_pkg.sv
src/host_pkg.sv
src/mem_port_if.sv
src/byte_ram.sv
src/ram.sv
src/host_access.sv
src/mem_top.sv
bench/tb_mem_top.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_mem_top
RTL_TOP   ?= mem_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides pass or fail
run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(filter src/%,$(SOURCES))

clean:
	rm -rf $(BUILD_DIR) $(LOG)
